// File: filelist.f
verilog/dmem_pkg.sv
verilog/rv32_isa_pkg.sv
verilog/lsu_align.sv
verilog/amo_unit.sv
verilog/mem_stage.sv
verilog/data_ram.sv
verilog/mem_subsystem.sv
tests/tb_clock.sv
tests/mem_subsystem_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/100ps \
		--top-module mem_subsystem_tb -f filelist.f -o mem_subsystem_sim
	./obj_dir/mem_subsystem_sim | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: tests/mem_subsystem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem_tb
    import rv32_isa_pkg::*;
    import dmem_pkg::*;
();

    localparam int RAM_WORDS      = 256;
    localparam int RESP_LATENCY   = 2;
    localparam int N_STORE        = 32;
    localparam int N_LOAD         = 32;
    localparam int N_ALU          = 16;
    localparam int N_AMO          = 40;
    localparam int N_LRSC         = 12;
    localparam int N_INST         = N_STORE + N_LOAD + N_ALU + 2 * N_AMO + 4 * N_LRSC;
    localparam int TIMEOUT_CYCLES = N_INST * (2 * RESP_LATENCY + 4) + 100;
    localparam word_t      BASE   = 32'h0000_2000; // start of the 16-word window
    localparam logic [6:0] OP_ALU = 7'b0110011;    // register-register op, no memory

    logic       clk;
    logic       rst;
    logic       inst_valid;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] funct5;
    word_t      alu_result;
    word_t      rs2_v;
    logic [4:0] rd_s;
    logic       regf_we;
    logic       dstall;
    logic       amo;
    word_t      wb_rd_v;
    word_t      wb_read_data;
    logic [4:0] wb_rd_s;
    logic       wb_regf_we;
    word_t      wb_mem_addr;
    mask_t      wb_mem_rmask;
    mask_t      wb_mem_wmask;
    word_t      wb_mem_wdata;
    logic       lock;
    word_t      locked_address;

    integer      seed   = 33581;
    int          checks = 0;
    int          errors = 0;
    int          tests  = 0;
    word_t       mirror [16];  // reference copy of the window
    logic        lock_m;       // model reservation
    word_t       lock_addr_m;
    amo_funct5_t amo_ops [9] = '{amoswap, amoadd, amoxor, amoand, amoor,
                                 amomin, amomax, amominu, amomaxu};

    tb_clock #(.PERIOD(40)) u_clock (.clk(clk));

    mem_subsystem #(
        .RAM_WORDS    (RAM_WORDS),
        .RESP_LATENCY (RESP_LATENCY)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .opcode         (opcode),
        .funct3         (funct3),
        .funct5         (funct5),
        .alu_result     (alu_result),
        .rs2_v          (rs2_v),
        .rd_s           (rd_s),
        .regf_we        (regf_we),
        .dstall         (dstall),
        .amo            (amo),
        .wb_rd_v        (wb_rd_v),
        .wb_read_data   (wb_read_data),
        .wb_rd_s        (wb_rd_s),
        .wb_regf_we     (wb_regf_we),
        .wb_mem_addr    (wb_mem_addr),
        .wb_mem_rmask   (wb_mem_rmask),
        .wb_mem_wmask   (wb_mem_wmask),
        .wb_mem_wdata   (wb_mem_wdata),
        .lock           (lock),
        .locked_address (locked_address)
    );

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_mask(input string name, input mask_t exp, input mask_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    function automatic word_t next_word();
        return word_t'($random(seed));
    endfunction

    function automatic int pick_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // random address in the window, aligned to the access width
    function automatic word_t make_addr(input logic [2:0] f3);
        int         idx;
        logic [1:0] off;
        idx = pick_below(16);
        off = 2'(pick_below(4));
        if (f3[1:0] == 2'b01)
            off = off & 2'b10;
        else if (f3[1:0] == 2'b10)
            off = 2'b00;
        return BASE | (word_t'(idx) << 2) | word_t'(off);
    endfunction

    function automatic mask_t load_mask(input logic [2:0] f3, input logic [1:0] off);
        case (f3)
            lb, lbu: return mask_t'(4'b0001 << off);
            lh, lhu: return mask_t'(4'b0011 << off);
            lw:      return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic mask_t store_mask(input logic [2:0] f3, input logic [1:0] off);
        case (f3)
            sb:      return mask_t'(4'b0001 << off);
            sh:      return mask_t'(4'b0011 << off);
            sw:      return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    // store data moved into its byte lanes, zeros elsewhere
    function automatic word_t place_store_data(input logic [2:0] f3, input logic [1:0] off,
                                               input word_t v);
        case (f3)
            sb:      return word_t'(v[7:0]) << (8 * off);
            sh:      return word_t'(v[15:0]) << (8 * off);
            sw:      return v;
            default: return '0;
        endcase
    endfunction

    function automatic word_t extend_load(input word_t w, input logic [2:0] f3,
                                          input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * off));
        h = 16'(w >> (8 * off));
        case (f3)
            lb:      return {{24{b[7]}}, b};
            lbu:     return {24'h0, b};
            lh:      return {{16{h[15]}}, h};
            lhu:     return {16'h0, h};
            default: return w;
        endcase
    endfunction

    function automatic word_t merge_bytes(input word_t old, input mask_t m, input word_t d);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++)
            if (m[b])
                r[8*b +: 8] = d[8*b +: 8];
        return r;
    endfunction

    function automatic word_t amo_combine(input amo_funct5_t op, input word_t old, input word_t v);
        case (op)
            amoswap: return v;
            amoadd:  return old + v;
            amoxor:  return old ^ v;
            amoand:  return old & v;
            amoor:   return old | v;
            amomin:  return ($signed(old) < $signed(v)) ? old : v;
            amomax:  return ($signed(old) > $signed(v)) ? old : v;
            amominu: return (old < v) ? old : v;
            amomaxu: return (old > v) ? old : v;
            default: return old;
        endcase
    endfunction

    // one instruction: predict, drive, wait for the stall to drop, compare
    task automatic execute(input logic [6:0] opc, input logic [2:0] f3, input logic [4:0] f5,
                           input word_t addr, input word_t opnd);
        int         idx;
        int         cycles;
        int         n_stall;
        logic [1:0] off;
        logic [4:0] rd;
        logic       we;
        logic       sc_ok;
        logic       is_mem;
        word_t      waddr;
        word_t      old;
        word_t      new_word;
        word_t      exp_rd;
        word_t      exp_rdata;
        word_t      exp_wdata;
        mask_t      exp_rmask;
        mask_t      exp_wmask;

        idx       = int'(addr[5:2]);
        off       = addr[1:0];
        waddr     = {addr[31:2], 2'b00};
        old       = mirror[idx];
        new_word  = old;
        exp_rd    = addr;
        exp_rdata = '0;
        exp_wdata = '0;
        exp_rmask = '0;
        exp_wmask = '0;
        n_stall   = 1 + RESP_LATENCY;
        is_mem    = 1'b1;
        rd        = 5'(pick_below(32));
        we        = (pick_below(2) == 1);

        case (opc)
            op_b_load:
            begin
                exp_rmask = load_mask(f3, off);
                exp_rd    = extend_load(old, f3, off);
                exp_rdata = exp_rd;
            end
            op_b_store:
            begin
                exp_wmask = store_mask(f3, off);
                exp_wdata = place_store_data(f3, off, opnd);
                new_word  = merge_bytes(old, exp_wmask, exp_wdata);
            end
            op_b_atom:
                if (f5 == lrw)
                begin
                    exp_rmask   = '1;
                    exp_rd      = old;
                    exp_rdata   = old;
                    lock_m      = 1'b1;
                    lock_addr_m = waddr;
                end
                else if (f5 == scw)
                begin
                    sc_ok  = lock_m && (lock_addr_m == waddr);
                    lock_m = 1'b0;
                    if (sc_ok)
                    begin
                        exp_wmask = '1;
                        exp_wdata = opnd;
                        new_word  = opnd;
                        exp_rd    = 0;
                    end
                    else
                    begin
                        exp_rd  = 1;
                        n_stall = 1; // no memory access at all
                    end
                end
                else
                begin
                    exp_rmask = '1;
                    exp_wmask = '1;
                    new_word  = amo_combine(amo_funct5_t'(f5), old, opnd);
                    exp_wdata = new_word;
                    exp_rd    = old;
                    exp_rdata = old;
                    n_stall   = 2 + 2 * RESP_LATENCY; // read phase then write phase
                end
            default:
            begin
                is_mem  = 1'b0;
                n_stall = 0;
            end
        endcase

        @(posedge clk);
        #2;
        inst_valid = 1'b1;
        opcode     = opc;
        funct3     = f3;
        funct5     = f5;
        alu_result = addr;
        rs2_v      = opnd;
        rd_s       = rd;
        regf_we    = we;

        cycles = 0;
        @(negedge clk);
        while (dstall)
        begin
            cycles++;
            @(negedge clk);
        end

        checks++;
        if (cycles != n_stall)
        begin
            errors++;
            $display("timing error: dstall stayed high for %0d cycles instead of %0d (opcode %h)",
                     cycles, n_stall, opc);
        end

        check_word("wb_rd_v", exp_rd, wb_rd_v);
        check_word("wb_read_data", exp_rdata, wb_read_data);
        check_mask("wb_mem_rmask", exp_rmask, wb_mem_rmask);
        check_mask("wb_mem_wmask", exp_wmask, wb_mem_wmask);
        if (exp_wmask != '0)
            check_word("wb_mem_wdata", exp_wdata, wb_mem_wdata);
        check_word("wb_mem_addr", is_mem ? waddr : '0, wb_mem_addr);
        check_word("wb_rd_s", word_t'(rd), word_t'(wb_rd_s));
        check_bit("wb_regf_we", we, wb_regf_we);
        check_bit("amo", opc == op_b_atom, amo);
        check_bit("lock", lock_m, lock);
        check_word("locked_address", lock_addr_m, locked_address);

        mirror[idx] = new_word;
    endtask

    task automatic finish_test(input string name, input int e0, input int c0);
        tests++;
        $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    task automatic stores_then_loads();
        int         e0;
        int         c0;
        logic [2:0] f3;
        word_t      addr;
        e0 = errors;
        c0 = checks;
        for (int i = 0; i < N_STORE; i++)
        begin
            case (pick_below(3))
                0:       f3 = sb;
                1:       f3 = sh;
                default: f3 = sw;
            endcase
            addr = make_addr(f3);
            execute(op_b_store, f3, 5'b0, addr, next_word());
        end
        for (int i = 0; i < N_LOAD; i++)
        begin
            case (pick_below(5))
                0:       f3 = lb;
                1:       f3 = lbu;
                2:       f3 = lh;
                3:       f3 = lhu;
                default: f3 = lw;
            endcase
            addr = make_addr(f3);
            execute(op_b_load, f3, 5'b0, addr, next_word());
        end
        finish_test("stores then loads", e0, c0);
    endtask

    task automatic plain_alu_ops();
        int e0;
        int c0;
        e0 = errors;
        c0 = checks;
        for (int i = 0; i < N_ALU; i++)
            execute(OP_ALU, 3'(pick_below(8)), 5'b0, next_word(), next_word());
        finish_test("non-memory", e0, c0);
    endtask

    task automatic atomic_ops();
        int    e0;
        int    c0;
        word_t addr;
        e0 = errors;
        c0 = checks;
        for (int i = 0; i < N_AMO; i++)
        begin
            addr = make_addr(lw);
            execute(op_b_atom, lw, amo_ops[pick_below(9)], addr, next_word());
            execute(op_b_load, lw, 5'b0, addr, 32'h0); // read back the combined word
        end
        finish_test("amo", e0, c0);
    endtask

    task automatic lr_sc_pairs();
        int    e0;
        int    c0;
        int    other;
        word_t a;
        word_t b;
        e0 = errors;
        c0 = checks;
        for (int i = 0; i < N_LRSC; i++)
        begin
            a = make_addr(lw);
            execute(op_b_atom, lw, lrw, a, next_word());
            if (pick_below(2) == 0)
                b = a;
            else
            begin
                other = (int'(a[5:2]) + 1 + pick_below(15)) % 16; // any other word
                b     = BASE | (word_t'(other) << 2);
            end
            execute(op_b_atom, lw, scw, b, next_word());
            execute(op_b_atom, lw, scw, b, next_word()); // reservation is gone by now
            execute(op_b_load, lw, 5'b0, b, 32'h0);
        end
        finish_test("lr/sc", e0, c0);
    endtask

    initial
    begin
        rst         = 1'b1;
        inst_valid  = 1'b0;
        opcode      = '0;
        funct3      = '0;
        funct5      = '0;
        alu_result  = '0;
        rs2_v       = '0;
        rd_s        = '0;
        regf_we     = 1'b0;
        lock_m      = 1'b0;
        lock_addr_m = '0;
        for (int i = 0; i < 16; i++)
            mirror[i] = '0; // RAM powers up cleared

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        check_bit("dstall", 1'b0, dstall);
        check_bit("lock", 1'b0, lock);
        check_word("locked_address", '0, locked_address);
        finish_test("reset state", 0, 0);

        stores_then_loads();
        plain_alu_ops();
        atomic_ops();
        lr_sc_pairs();

        @(posedge clk);
        #2;
        inst_valid = 1'b0;

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // watchdog, sized for the slowest instruction mix
    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog: the DUT stalled and the run did not finish in %0d cycles",
                 TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

// free-running clock for the testbench
module tb_clock #(
    parameter int PERIOD = 40
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: verilog/mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem
    import dmem_pkg::*;
#(
    parameter int RAM_WORDS    = 256,
    parameter int RESP_LATENCY = 2
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_valid,
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [4:0] funct5,
    input  word_t      alu_result,
    input  word_t      rs2_v,
    input  logic [4:0] rd_s,
    input  logic       regf_we,
    output logic       dstall,
    output logic       amo,
    output word_t      wb_rd_v,
    output word_t      wb_read_data,
    output logic [4:0] wb_rd_s,
    output logic       wb_regf_we,
    output word_t      wb_mem_addr,
    output mask_t      wb_mem_rmask,
    output mask_t      wb_mem_wmask,
    output word_t      wb_mem_wdata,
    output logic       lock,
    output word_t      locked_address
);

    word_t dmem_addr, dmem_wdata, dmem_rdata;
    mask_t dmem_rmask, dmem_wmask;
    logic  dmem_resp;

    mem_stage u_mem_stage (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .opcode         (opcode),
        .funct3         (funct3),
        .funct5         (funct5),
        .alu_result     (alu_result),
        .rs2_v          (rs2_v),
        .rd_s           (rd_s),
        .regf_we        (regf_we),
        .dmem_rdata     (dmem_rdata),
        .dmem_resp      (dmem_resp),
        .dmem_addr      (dmem_addr),
        .dmem_rmask     (dmem_rmask),
        .dmem_wmask     (dmem_wmask),
        .dmem_wdata     (dmem_wdata),
        .dstall         (dstall),
        .amo            (amo),
        .wb_rd_v        (wb_rd_v),
        .wb_read_data   (wb_read_data),
        .wb_rd_s        (wb_rd_s),
        .wb_regf_we     (wb_regf_we),
        .wb_mem_addr    (wb_mem_addr),
        .wb_mem_rmask   (wb_mem_rmask),
        .wb_mem_wmask   (wb_mem_wmask),
        .wb_mem_wdata   (wb_mem_wdata),
        .lock           (lock),
        .locked_address (locked_address)
    );

    data_ram #(
        .RAM_WORDS    (RAM_WORDS),
        .RESP_LATENCY (RESP_LATENCY)
    ) u_data_ram (
        .clk        (clk),
        .rst        (rst),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp)
    );

endmodule

`default_nettype wire

// File: verilog/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram
    import dmem_pkg::*;
#(
    parameter int RAM_WORDS    = 256,
    parameter int RESP_LATENCY = 2
)
(
    input  logic  clk,
    input  logic  rst,
    input  word_t dmem_addr,
    input  mask_t dmem_rmask,
    input  mask_t dmem_wmask,
    input  word_t dmem_wdata,
    output word_t dmem_rdata,
    output logic  dmem_resp
);

    localparam int IDX_W = $clog2(RAM_WORDS);
    localparam int CNT_W = $clog2(RESP_LATENCY + 1);

    word_t            mem [RAM_WORDS] = '{default: '0};
    logic             req;
    logic             busy;
    logic [CNT_W-1:0] cnt;     // cycles left until the response
    logic [IDX_W-1:0] idx_q;
    mask_t            wmask_q;
    word_t            wdata_q;

    assign req        = |(dmem_rmask | dmem_wmask);
    assign dmem_resp  = busy && (cnt == '0);
    assign dmem_rdata = mem[idx_q]; // old contents until the response edge

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            cnt  <= '0;
        end
        else if (!busy)
        begin
            if (req)
            begin
                busy <= 1'b1;
                cnt  <= CNT_W'(RESP_LATENCY - 1);
            end
        end
        else if (dmem_resp)
            busy <= 1'b0; // a request still held in this cycle is not restarted
        else
            cnt <= cnt - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!busy && req)
        begin
            idx_q   <= dmem_addr[OFFSET_W +: IDX_W]; // wraps modulo RAM_WORDS
            wmask_q <= dmem_wmask;
            wdata_q <= dmem_wdata;
        end
        if (dmem_resp)
            for (int b = 0; b < MASK_W; b++)
                if (wmask_q[b])
                    mem[idx_q][b*BYTE_W +: BYTE_W] <= wdata_q[b*BYTE_W +: BYTE_W];
    end

    // the requester still holds its request when the response comes
    resp_needs_request: assert property (@(posedge clk) disable iff (rst)
        dmem_resp |-> req);

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage
    import rv32_isa_pkg::*;
    import dmem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_valid,
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [4:0] funct5,
    input  word_t      alu_result,
    input  word_t      rs2_v,
    input  logic [4:0] rd_s,
    input  logic       regf_we,
    input  word_t      dmem_rdata,
    input  logic       dmem_resp,
    output word_t      dmem_addr,
    output mask_t      dmem_rmask,
    output mask_t      dmem_wmask,
    output word_t      dmem_wdata,
    output logic       dstall,
    output logic       amo,
    output word_t      wb_rd_v,
    output word_t      wb_read_data,
    output logic [4:0] wb_rd_s,
    output logic       wb_regf_we,
    output word_t      wb_mem_addr,
    output mask_t      wb_mem_rmask,
    output mask_t      wb_mem_wmask,
    output word_t      wb_mem_wdata,
    output logic       lock,
    output word_t      locked_address
);

    logic        mem_read, mem_write, amo_valid, mem_inst;
    logic        is_sc, sc_dead, start, done, stall_q;
    logic        issue_rd, issue_wr;
    logic        amo_done, amo_mem_read, amo_mem_write, sc_fail;
    amo_funct5_t amo_funct;
    word_t       word_addr, wdata, load_data, amo_wdata;
    word_t       rdata_latch, old_word;
    mask_t       rmask, wmask;

    assign mem_read  = inst_valid && (opcode == op_b_load);
    assign mem_write = inst_valid && (opcode == op_b_store);
    assign amo_valid = inst_valid && (opcode == op_b_atom);
    assign mem_inst  = mem_read || mem_write || amo_valid;
    assign amo       = amo_valid;
    assign amo_funct = amo_funct5_t'(funct5);
    assign is_sc     = (funct5 == scw);
    assign sc_dead   = amo_valid && is_sc && sc_fail; // SC without memory access

    // stall rises on acceptance, drops in the completing cycle
    assign start  = mem_inst && !stall_q;
    assign done   = amo_valid ? amo_done : dmem_resp;
    assign dstall = start || (stall_q && !done);

    always_ff @(posedge clk)
    begin
        if (rst)
            stall_q <= 1'b0;
        else if (start)
            stall_q <= 1'b1;
        else if (stall_q && done)
            stall_q <= 1'b0;
    end

    // old word of the read phase
    always_ff @(posedge clk)
    begin
        if (amo_mem_read && dmem_resp)
            rdata_latch <= dmem_rdata;
    end

    assign old_word = (amo_mem_read && dmem_resp) ? dmem_rdata : rdata_latch; // LR ends here

    // one request per access, held until the response
    assign issue_rd   = (stall_q && mem_read) || amo_mem_read;
    assign issue_wr   = (stall_q && mem_write) || amo_mem_write;
    assign dmem_addr  = (issue_rd || issue_wr) ? word_addr : '0;
    assign dmem_rmask = issue_rd ? rmask : '0;
    assign dmem_wmask = issue_wr ? wmask : '0;
    assign dmem_wdata = issue_wr ? wdata : '0;

    always_comb
    begin
        wb_read_data = '0;
        if (mem_read)
        begin
            wb_rd_v      = load_data;
            wb_read_data = load_data;
        end
        else if (amo_valid && is_sc)
            wb_rd_v = {{(XLEN-1){1'b0}}, sc_fail}; // 0 on success
        else if (amo_valid)
        begin
            wb_rd_v      = old_word;
            wb_read_data = old_word;
        end
        else
            wb_rd_v = alu_result;
    end

    assign wb_rd_s      = rd_s;
    assign wb_regf_we   = regf_we;
    assign wb_mem_addr  = mem_inst ? word_addr : '0;
    assign wb_mem_rmask = rmask;
    assign wb_mem_wmask = sc_dead ? '0 : wmask;
    assign wb_mem_wdata = sc_dead ? '0 : wdata;

    lsu_align u_lsu_align (
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .amo_valid  (amo_valid),
        .funct3     (funct3),
        .funct5     (funct5),
        .alu_result (alu_result),
        .rs2_v      (rs2_v),
        .amo_wdata  (amo_wdata),
        .dmem_rdata (dmem_rdata),
        .word_addr  (word_addr),
        .rmask      (rmask),
        .wmask      (wmask),
        .wdata      (wdata),
        .load_data  (load_data)
    );

    amo_unit u_amo_unit (
        .clk             (clk),
        .rst             (rst),
        .amo_valid       (amo_valid),
        .amo_funct       (amo_funct),
        .amo_operand     (rs2_v),
        .mem_data_in     (rdata_latch),
        .address_to_lock (word_addr),
        .mem_resp        (dmem_resp),
        .mem_data_out    (amo_wdata),
        .amo_done        (amo_done),
        .mem_read        (amo_mem_read),
        .mem_write       (amo_mem_write),
        .sc_fail         (sc_fail),
        .lock            (lock),
        .locked_address  (locked_address)
    );

    // read and write phases come from separate sources and must never overlap
    masks_exclusive: assert property (@(posedge clk) disable iff (rst)
        !((|dmem_rmask) && (|dmem_wmask)));

endmodule

`default_nettype wire

// File: verilog/amo_unit.sv
`timescale 1ns/100ps
`default_nettype none

module amo_unit
    import rv32_isa_pkg::*;
    import dmem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        amo_valid,
    input  amo_funct5_t amo_funct,
    input  word_t       amo_operand,     // rs2 value
    input  word_t       mem_data_in,     // old word from the read phase
    input  word_t       address_to_lock,
    input  logic        mem_resp,
    output word_t       mem_data_out,
    output logic        amo_done,
    output logic        mem_read,
    output logic        mem_write,
    output logic        sc_fail,
    output logic        lock,
    output word_t       locked_address
);

    typedef enum logic [1:0] {st_idle, st_read, st_write, st_done} state_t;

    state_t state;
    logic   sc_match;
    logic   lt_s;
    logic   lt_u;

    assign sc_match = lock && (locked_address == address_to_lock);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state          <= st_idle;
            lock           <= 1'b0;
            locked_address <= '0;
            sc_fail        <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (amo_valid)
                    begin
                        sc_fail <= 1'b0;
                        case (amo_funct)
                            lrw:
                            begin
                                lock           <= 1'b1;
                                locked_address <= address_to_lock;
                                state          <= st_read;
                            end
                            scw:
                            begin
                                lock    <= 1'b0; // cleared whether or not it matched
                                sc_fail <= !sc_match;
                                state   <= sc_match ? st_write : st_done;
                            end
                            default: state <= st_read;
                        endcase
                    end
                st_read:
                    if (mem_resp)
                        state <= (amo_funct == lrw) ? st_idle : st_write;
                st_write:
                    if (mem_resp)
                        state <= st_idle;
                default: state <= st_idle; // failed SC finishes here
            endcase
        end
    end

    assign mem_read  = (state == st_read);
    assign mem_write = (state == st_write);
    assign amo_done  = (mem_read && mem_resp && amo_funct == lrw)
                    || (mem_write && mem_resp)
                    || (state == st_done);

    assign lt_s = $signed(mem_data_in) < $signed(amo_operand);
    assign lt_u = mem_data_in < amo_operand;

    // new memory value
    always_comb
    begin
        case (amo_funct)
            amoswap, scw: mem_data_out = amo_operand;
            amoadd:       mem_data_out = mem_data_in + amo_operand;
            amoxor:       mem_data_out = mem_data_in ^ amo_operand;
            amoand:       mem_data_out = mem_data_in & amo_operand;
            amoor:        mem_data_out = mem_data_in | amo_operand;
            amomin:       mem_data_out = lt_s ? mem_data_in : amo_operand;
            amomax:       mem_data_out = lt_s ? amo_operand : mem_data_in;
            amominu:      mem_data_out = lt_u ? mem_data_in : amo_operand;
            amomaxu:      mem_data_out = lt_u ? amo_operand : mem_data_in;
            default:      mem_data_out = mem_data_in;
        endcase
    end

    // every completion belongs to an instruction that has been held since its start
    done_needs_valid: assert property (@(posedge clk) disable iff (rst)
        amo_done |-> amo_valid && $past(amo_valid));

endmodule

`default_nettype wire

// File: verilog/lsu_align.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_align
    import rv32_isa_pkg::*;
    import dmem_pkg::*;
(
    input  logic       mem_read,
    input  logic       mem_write,
    input  logic       amo_valid,
    input  logic [2:0] funct3,
    input  logic [4:0] funct5,
    input  word_t      alu_result,
    input  word_t      rs2_v,
    input  word_t      amo_wdata,
    input  word_t      dmem_rdata,
    output word_t      word_addr,
    output mask_t      rmask,
    output mask_t      wmask,
    output word_t      wdata,
    output word_t      load_data
);

    logic [OFFSET_W-1:0] slide;    // byte offset of the access
    logic [BYTE_W-1:0]   byte_v;
    logic [2*BYTE_W-1:0] half_v;

    assign word_addr = {alu_result[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign slide     = alu_result[OFFSET_W-1:0];

    always_comb
    begin
        rmask = '0;
        wmask = '0;
        wdata = '0;
        if (mem_read)
        begin
            case (funct3)
                lb, lbu: rmask = mask_t'(1) << slide;
                lh, lhu: rmask = mask_t'(3) << slide;
                lw:      rmask = '1;
                default: rmask = '0;
            endcase
        end
        else if (mem_write)
        begin
            case (funct3)
                sb:
                begin
                    wmask = mask_t'(1) << slide;
                    wdata[BYTE_W*slide +: BYTE_W] = rs2_v[BYTE_W-1:0];
                end
                sh:
                begin
                    wmask = mask_t'(3) << slide;
                    wdata[2*BYTE_W*slide[1] +: 2*BYTE_W] = rs2_v[2*BYTE_W-1:0];
                end
                sw:
                begin
                    wmask = '1;
                    wdata = rs2_v;
                end
                default: wmask = '0;
            endcase
        end
        else if (amo_valid)
        begin
            // atomics are always full words
            rmask = (funct5 == scw) ? '0 : '1;
            wmask = (funct5 == lrw) ? '0 : '1;
            wdata = amo_wdata;
        end
    end

    // pick the addressed lane, then extend
    assign byte_v = dmem_rdata[BYTE_W*slide +: BYTE_W];
    assign half_v = dmem_rdata[2*BYTE_W*slide[1] +: 2*BYTE_W];

    always_comb
    begin
        case (funct3)
            lb:      load_data = {{(XLEN-BYTE_W){byte_v[BYTE_W-1]}}, byte_v};
            lbu:     load_data = {{(XLEN-BYTE_W){1'b0}}, byte_v};
            lh:      load_data = {{(XLEN-2*BYTE_W){half_v[2*BYTE_W-1]}}, half_v};
            lhu:     load_data = {{(XLEN-2*BYTE_W){1'b0}}, half_v};
            default: load_data = dmem_rdata; // lw
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv32_isa_pkg.sv
`default_nettype none

// instruction set encodings seen by the memory stage
package rv32_isa_pkg;

    // major opcodes
    localparam logic [6:0] op_b_load  = 7'b0000011;
    localparam logic [6:0] op_b_store = 7'b0100011;
    localparam logic [6:0] op_b_atom  = 7'b0101111; // AMO, LR, SC

    // load widths, funct3
    localparam logic [2:0] lb  = 3'b000;
    localparam logic [2:0] lh  = 3'b001;
    localparam logic [2:0] lw  = 3'b010;
    localparam logic [2:0] lbu = 3'b100;
    localparam logic [2:0] lhu = 3'b101;

    // store widths, funct3
    localparam logic [2:0] sb = 3'b000;
    localparam logic [2:0] sh = 3'b001;
    localparam logic [2:0] sw = 3'b010;

    // upper five bits of funct7 for the A extension
    // aq and rl sit below these and are not decoded
    typedef enum logic [4:0] {
        amoadd  = 5'b00000,
        amoswap = 5'b00001,
        lrw     = 5'b00010,
        scw     = 5'b00011,
        amoxor  = 5'b00100,
        amoor   = 5'b01000,
        amoand  = 5'b01100,
        amomin  = 5'b10000,
        amomax  = 5'b10100,
        amominu = 5'b11000,
        amomaxu = 5'b11100
    } amo_funct5_t;

endpackage

`default_nettype wire

// File: verilog/dmem_pkg.sv
`default_nettype none

// data memory geometry
package dmem_pkg;

    localparam int XLEN     = 32;           // data word width
    localparam int BYTE_W   = 8;
    localparam int MASK_W   = XLEN / BYTE_W; // bytes per word
    localparam int OFFSET_W = $clog2(MASK_W); // byte offset bits inside a word

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [MASK_W-1:0] mask_t;

endpackage

`default_nettype wire
